//--- src.f
cu_pkg.sv
instr_decoder.sv
stack_sequencer.sv
control_merge.sv
control_unit.sv
tb_clock.sv
tb_control_unit.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_control_unit
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_control_unit.sv
`default_nettype none

module tb_control_unit
  import cu_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ns;

  localparam int clk_period    = 40;
  localparam int test_cycles   = 80 + 200 * 4;
  localparam int margin_cycles = 100;

  // every DUT output in one vector, so a single check covers a whole cycle
  typedef struct packed {
    logic       int_ack;
    logic       reg_wr;
    logic       ldm;
    logic       mem_to_reg;
    logic       port_r;
    logic       port_w;
    logic       branch;
    logic       call;
    logic       ret;
    logic       rti;
    logic [4:0] alu_op;
    logic [1:0] alu_src;
    logic       mem_r;
    logic       mem_w;
    logic       stack;
    logic       freeze_cu;
    logic       fetch_pc_enable;
    logic       pop_pc1;
    logic       pop_pc2;
    logic       pop_ccr;
    logic [1:0] mem_data_sel;
    logic [1:0] pc_sel;
  } outs_t;

  typedef struct packed {
    logic       reg_wr;
    logic       ldm;
    logic       mem_r;
    logic       mem_w;
    logic       mem_to_reg;
    logic       stack;
    logic       port_r;
    logic       port_w;
    logic       branch;
    logic       call;
    logic       ret;
    logic       rti;
    logic [1:0] alu_src;
  } dec_ref_t;

  // what the stack sequences add on top of the decoded instruction
  typedef struct packed {
    logic       mem_r;
    logic       mem_w;
    logic       stack;
    logic       freeze_pc;
    logic       freeze_cu;
    logic       pop_ccr;
    logic       pop_pc2;
    logic       pop_pc1;
    logic [1:0] mds;
    logic [1:0] pc_sel;
  } seq_ref_t;

  localparam seq_ref_t ex_idle      = '0;
  localparam seq_ref_t ex_ldm_hold  = '{freeze_cu: 1'b1, default: '0};
  localparam seq_ref_t ex_fz_pc     = '{freeze_pc: 1'b1, default: '0};
  localparam seq_ref_t ex_fz_both   = '{freeze_pc: 1'b1, freeze_cu: 1'b1, default: '0};
  localparam seq_ref_t ex_call_load = '{pc_sel: 2'b11, default: '0};
  localparam seq_ref_t ex_push1     = '{mem_w: 1'b1, stack: 1'b1, freeze_pc: 1'b1,
                                        freeze_cu: 1'b1, mds: 2'b01, default: '0};
  localparam seq_ref_t ex_push2     = '{mem_w: 1'b1, stack: 1'b1, freeze_pc: 1'b1,
                                        freeze_cu: 1'b1, mds: 2'b10, default: '0};
  localparam seq_ref_t ex_push_ccr  = '{mem_w: 1'b1, stack: 1'b1, freeze_pc: 1'b1,
                                        freeze_cu: 1'b1, mds: 2'b11, pc_sel: 2'b10,
                                        default: '0};
  localparam seq_ref_t ex_pop2      = '{mem_r: 1'b1, stack: 1'b1, freeze_pc: 1'b1,
                                        freeze_cu: 1'b1, pop_pc2: 1'b1, default: '0};
  localparam seq_ref_t ex_pop1      = '{mem_r: 1'b1, stack: 1'b1, freeze_pc: 1'b1,
                                        freeze_cu: 1'b1, pop_pc1: 1'b1, default: '0};
  localparam seq_ref_t ex_pop_ccr   = '{mem_r: 1'b1, stack: 1'b1, freeze_pc: 1'b1,
                                        freeze_cu: 1'b1, pop_ccr: 1'b1, default: '0};

  logic          clk;
  logic          rst;
  opcode_t       opcode;
  logic          branch_taken;
  logic          load_use;
  logic          int_req;
  logic          int_ack;
  logic          reg_wr;
  logic          ldm;
  logic          mem_to_reg;
  logic          port_r;
  logic          port_w;
  logic          branch;
  alu_op_t       alu_op;
  alu_src_t      alu_src;
  logic          mem_r;
  logic          mem_w;
  logic          stack;
  logic          freeze_cu;
  logic          fetch_pc_enable;
  logic          pop_pc1;
  logic          pop_pc2;
  logic          pop_ccr;
  logic          call;
  logic          ret;
  logic          rti;
  mem_data_sel_t mem_data_sel;
  pc_sel_t       pc_sel;

  outs_t    got;
  outs_t    want;
  dec_ref_t dec_want;
  seq_ref_t seq_want;
  logic     ack_want;
  logic     side_rand;
  logic     checks_on;
  int       seed;
  int       value_errors;
  int       other_errors;

  tb_clock #(.period_ns(clk_period)) clk_gen (.clk(clk));

  control_unit uut (.*);

  assign got = {int_ack, reg_wr, ldm, mem_to_reg, port_r, port_w, branch, call, ret, rti,
                alu_op, alu_src, mem_r, mem_w, stack, freeze_cu, fetch_pc_enable,
                pop_pc1, pop_pc2, pop_ccr, mem_data_sel, pc_sel};

  // opcode table of the instruction set
  function automatic dec_ref_t decode_ref(input logic [4:0] op);
    dec_ref_t r;
    logic     alu_grp;
    logic     jmp_grp;
    alu_grp      = (op[4:3] == 2'b01);
    jmp_grp      = (op[4:2] == 3'b101);
    r.reg_wr     = alu_grp || op == op_ldd || op == op_ldm || op == op_pop || op == op_in;
    r.ldm        = (op == op_ldm);
    r.mem_r      = (op == op_ldd || op == op_pop);
    r.mem_w      = (op == op_std || op == op_push);
    r.mem_to_reg = (op == op_ldd || op == op_pop);
    r.stack      = (op == op_push || op == op_pop);
    r.port_r     = (op == op_in);
    r.port_w     = (op == op_out);
    r.branch     = jmp_grp;
    r.call       = (op == op_call);
    r.ret        = (op == op_ret);
    r.rti        = (op == op_rti);
    r.alu_src    = {op == op_ldm, op == op_ldd || op == op_std};
    return r;
  endfunction

  always_comb
  begin
    dec_want             = decode_ref(opcode);
    want.int_ack         = ack_want;
    want.reg_wr          = dec_want.reg_wr;
    want.ldm             = dec_want.ldm;
    want.mem_to_reg      = dec_want.mem_to_reg;
    want.port_r          = dec_want.port_r;
    want.port_w          = dec_want.port_w;
    want.branch          = dec_want.branch;
    want.call            = dec_want.call;
    want.ret             = dec_want.ret;
    want.rti             = dec_want.rti;
    want.alu_op          = opcode;
    want.alu_src         = dec_want.alu_src;
    want.mem_r           = dec_want.mem_r | seq_want.mem_r;
    want.mem_w           = dec_want.mem_w | seq_want.mem_w;
    want.stack           = dec_want.stack | seq_want.stack;
    want.freeze_cu       = load_use | seq_want.freeze_cu;
    want.fetch_pc_enable = ~seq_want.freeze_pc;
    want.pop_pc1         = seq_want.pop_pc1;
    want.pop_pc2         = seq_want.pop_pc2;
    want.pop_ccr         = seq_want.pop_ccr;
    want.mem_data_sel    = seq_want.mds;
    // a running sequence wins over a taken branch
    if (seq_want.pc_sel != 2'b00)
      want.pc_sel = seq_want.pc_sel;
    else if (branch_taken)
      want.pc_sel = 2'b01;
    else
      want.pc_sel = 2'b00;
  end

  task automatic check_field(input string name, input logic [4:0] g, input logic [4:0] w);
    if (g !== w)
    begin
      value_errors++;
      $display("** Error %s: got %h, expected %h at %0t", name, g, w, $time);
    end
  endtask

  task automatic show_mismatch(input outs_t g, input outs_t w);
    check_field("int_ack", g.int_ack, w.int_ack);
    check_field("reg_wr", g.reg_wr, w.reg_wr);
    check_field("ldm", g.ldm, w.ldm);
    check_field("mem_to_reg", g.mem_to_reg, w.mem_to_reg);
    check_field("port_r", g.port_r, w.port_r);
    check_field("port_w", g.port_w, w.port_w);
    check_field("branch", g.branch, w.branch);
    check_field("call", g.call, w.call);
    check_field("ret", g.ret, w.ret);
    check_field("rti", g.rti, w.rti);
    check_field("alu_op", g.alu_op, w.alu_op);
    check_field("alu_src", g.alu_src, w.alu_src);
    check_field("mem_r", g.mem_r, w.mem_r);
    check_field("mem_w", g.mem_w, w.mem_w);
    check_field("stack", g.stack, w.stack);
    check_field("freeze_cu", g.freeze_cu, w.freeze_cu);
    check_field("fetch_pc_enable", g.fetch_pc_enable, w.fetch_pc_enable);
    check_field("pop_pc1", g.pop_pc1, w.pop_pc1);
    check_field("pop_pc2", g.pop_pc2, w.pop_pc2);
    check_field("pop_ccr", g.pop_ccr, w.pop_ccr);
    check_field("mem_data_sel", g.mem_data_sel, w.mem_data_sel);
    check_field("pc_sel", g.pc_sel, w.pc_sel);
  endtask

  a_outputs: assert property (@(posedge clk) disable iff (!checks_on) got === want)
  else
    show_mismatch($sampled(got), $sampled(want));

  a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
    $rose(int_ack) |-> $past(int_req))
  else
  begin
    other_errors++;
    $display("int_ack rose without a pending int_req at %0t", $time);
  end

  a_ack_drop: assert property (@(posedge clk) disable iff (rst)
    $fell(int_ack) |-> !$past(int_req))
  else
  begin
    other_errors++;
    $display("int_ack dropped while int_req was still high at %0t", $time);
  end

  // inputs and expectations change together on the falling edge
  task automatic drive_cycle(input opcode_t op, input seq_ref_t exp_seq, input logic exp_ack);
    int rnd;
    opcode   = op;
    seq_want = exp_seq;
    ack_want = exp_ack;
    if (side_rand)
    begin
      rnd          = $random(seed);
      branch_taken = rnd[0];
      load_use     = rnd[1];
    end
    @(negedge clk);
  endtask

  task automatic run_call;
    drive_cycle(op_call, ex_idle, 1'b0);
    drive_cycle(op_nop, ex_push1, 1'b0);
    drive_cycle(op_nop, ex_push2, 1'b0);
    drive_cycle(op_nop, ex_call_load, 1'b0);
  endtask

  // mid_op shows up in the pop2 cycle and must not disturb the sequence
  task automatic run_ret(input opcode_t mid_op);
    drive_cycle(op_ret, ex_idle, 1'b0);
    drive_cycle(mid_op, ex_pop2, 1'b0);
    drive_cycle(op_nop, ex_pop1, 1'b0);
  endtask

  task automatic run_rti;
    drive_cycle(op_rti, ex_idle, 1'b0);
    drive_cycle(op_nop, ex_pop_ccr, 1'b0);
    drive_cycle(op_nop, ex_pop2, 1'b0);
    drive_cycle(op_nop, ex_pop1, 1'b0);
  endtask

  task automatic run_ldm;
    drive_cycle(op_ldm, ex_idle, 1'b0);
    drive_cycle(op_nop, ex_ldm_hold, 1'b0);
  endtask

  task automatic run_interrupt(input logic hazard, input logic second_req);
    int_req = 1'b1;
    drive_cycle(op_nop, ex_idle, 1'b0);
    // ack is up, the requester lets go
    int_req  = 1'b0;
    load_use = hazard;
    drive_cycle(op_nop, ex_idle, 1'b1);
    load_use = 1'b0;
    if (hazard)
      drive_cycle(op_nop, ex_idle, 1'b1);
    drive_cycle(op_nop, ex_fz_pc, 1'b1);
    if (second_req)
      int_req = 1'b1;
    drive_cycle(op_nop, ex_fz_both, 1'b1);
    drive_cycle(op_nop, ex_push1, 1'b1);
    drive_cycle(op_nop, ex_push2, 1'b1);
    drive_cycle(op_nop, ex_push_ccr, 1'b1);
    drive_cycle(op_nop, ex_idle, 1'b1);
    if (second_req)
    begin
      int_req = 1'b0;
      drive_cycle(op_nop, ex_idle, 1'b1);
    end
    drive_cycle(op_nop, ex_idle, 1'b0);
  endtask

  task automatic run_random_op;
    int      rnd;
    opcode_t op;
    rnd = $random(seed);
    op  = rnd[4:0];
    if (op == op_call)
      run_call();
    else if (op == op_ret)
      run_ret(op_nop);
    else if (op == op_rti)
      run_rti();
    else if (op == op_ldm)
      run_ldm();
    else
      drive_cycle(op, ex_idle, 1'b0);
  endtask

  task automatic print_counts;
    $display("value errors %0d, other errors %0d", value_errors, other_errors);
  endtask

  initial
  begin
    rst          = 1'b1;
    opcode       = op_nop;
    branch_taken = 1'b0;
    load_use     = 1'b0;
    int_req      = 1'b0;
    seq_want     = ex_idle;
    ack_want     = 1'b0;
    side_rand    = 1'b0;
    checks_on    = 1'b0;
    seed         = 82;
    value_errors = 0;
    other_errors = 0;

    @(posedge clk);
    @(negedge clk);
    checks_on = 1'b1;
    // triggers held during reset must not start anything
    opcode  = op_call;
    int_req = 1'b1;
    repeat (4) @(negedge clk);
    rst     = 1'b0;
    int_req = 1'b0;
    drive_cycle(op_nop, ex_idle, 1'b0);
    drive_cycle(op_nop, ex_idle, 1'b0);

    run_call();
    run_ret(op_nop);
    run_rti();
    run_ldm();
    load_use = 1'b1;
    drive_cycle(op_nop, ex_idle, 1'b0);
    load_use = 1'b0;

    run_interrupt(1'b0, 1'b0);
    run_interrupt(1'b1, 1'b0);
    run_interrupt(1'b0, 1'b1);

    run_ret(op_call);
    drive_cycle(op_nop, ex_idle, 1'b0);

    side_rand = 1'b1;
    repeat (200) run_random_op();
    side_rand    = 1'b0;
    branch_taken = 1'b0;
    load_use     = 1'b0;
    drive_cycle(op_nop, ex_idle, 1'b0);

    print_counts();
    if (value_errors == 0 && other_errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    #((test_cycles + margin_cycles) * clk_period);
    other_errors++;
    $display("watchdog expired, the run did not finish in %0d cycles",
             test_cycles + margin_cycles);
    print_counts();
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_clock.sv
`default_nettype none

module tb_clock
#(
  parameter int period_ns = 40
)
(
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ns;

  // starts low so the first rising edge lands half a period in
  initial
  begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- control_unit.sv
`default_nettype none

module control_unit
  import cu_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  opcode_t       opcode,
  input  logic          branch_taken,
  input  logic          load_use,
  input  logic          int_req,
  output logic          int_ack,
  output logic          reg_wr,
  output logic          ldm,
  output logic          mem_to_reg,
  output logic          port_r,
  output logic          port_w,
  output logic          branch,
  output alu_op_t       alu_op,
  output alu_src_t      alu_src,
  output logic          mem_r,
  output logic          mem_w,
  output logic          stack,
  output logic          freeze_cu,
  output logic          fetch_pc_enable,
  output logic          pop_pc1,
  output logic          pop_pc2,
  output logic          pop_ccr,
  output logic          call,
  output logic          ret,
  output logic          rti,
  output mem_data_sel_t mem_data_sel,
  output pc_sel_t       pc_sel
);

  logic    mem_r_dec;
  logic    mem_w_dec;
  logic    stack_dec;
  logic    call_dec;
  logic    ret_dec;
  logic    rti_dec;
  logic    push_pc1;
  logic    push_pc2;
  logic    push_ccr;
  logic    seq_pop_pc1;
  logic    seq_pop_pc2;
  logic    seq_pop_ccr;
  logic    seq_mem_r;
  logic    seq_mem_w;
  logic    seq_stack;
  logic    seq_freeze_pc;
  logic    seq_freeze_cu;
  pc_sel_t seq_pc_sel;

  instr_decoder u_dec (
    .opcode     (opcode),
    .reg_wr     (reg_wr),
    .ldm_dec    (ldm),
    .mem_r_dec  (mem_r_dec),
    .mem_w_dec  (mem_w_dec),
    .mem_to_reg (mem_to_reg),
    .stack_dec  (stack_dec),
    .port_r     (port_r),
    .port_w     (port_w),
    .branch     (branch),
    .call_dec   (call_dec),
    .ret_dec    (ret_dec),
    .rti_dec    (rti_dec),
    .alu_op     (alu_op),
    .alu_src    (alu_src)
  );

  stack_sequencer u_seq (
    .clk           (clk),
    .rst           (rst),
    .call_dec      (call_dec),
    .ret_dec       (ret_dec),
    .rti_dec       (rti_dec),
    .ldm_dec       (ldm),
    .load_use      (load_use),
    .int_req       (int_req),
    .int_ack       (int_ack),
    .push_pc1      (push_pc1),
    .push_pc2      (push_pc2),
    .push_ccr      (push_ccr),
    .pop_pc1       (seq_pop_pc1),
    .pop_pc2       (seq_pop_pc2),
    .pop_ccr       (seq_pop_ccr),
    .seq_mem_r     (seq_mem_r),
    .seq_mem_w     (seq_mem_w),
    .seq_stack     (seq_stack),
    .seq_freeze_pc (seq_freeze_pc),
    .seq_freeze_cu (seq_freeze_cu),
    .seq_pc_sel    (seq_pc_sel)
  );

  control_merge u_merge (
    .clk             (clk),
    .rst             (rst),
    .mem_r_dec       (mem_r_dec),
    .mem_w_dec       (mem_w_dec),
    .stack_dec       (stack_dec),
    .call_dec        (call_dec),
    .ret_dec         (ret_dec),
    .rti_dec         (rti_dec),
    .push_pc1        (push_pc1),
    .push_pc2        (push_pc2),
    .push_ccr        (push_ccr),
    .seq_pop_pc1     (seq_pop_pc1),
    .seq_pop_pc2     (seq_pop_pc2),
    .seq_pop_ccr     (seq_pop_ccr),
    .seq_mem_r       (seq_mem_r),
    .seq_mem_w       (seq_mem_w),
    .seq_stack       (seq_stack),
    .seq_freeze_pc   (seq_freeze_pc),
    .seq_freeze_cu   (seq_freeze_cu),
    .seq_pc_sel      (seq_pc_sel),
    .branch_taken    (branch_taken),
    .load_use        (load_use),
    .mem_r           (mem_r),
    .mem_w           (mem_w),
    .stack           (stack),
    .freeze_cu       (freeze_cu),
    .fetch_pc_enable (fetch_pc_enable),
    .pop_pc1         (pop_pc1),
    .pop_pc2         (pop_pc2),
    .pop_ccr         (pop_ccr),
    .call            (call),
    .ret             (ret),
    .rti             (rti),
    .mem_data_sel    (mem_data_sel),
    .pc_sel          (pc_sel)
  );

endmodule

`default_nettype wire

//--- control_merge.sv
`default_nettype none

module control_merge
  import cu_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic          mem_r_dec,
  input  logic          mem_w_dec,
  input  logic          stack_dec,
  input  logic          call_dec,
  input  logic          ret_dec,
  input  logic          rti_dec,
  input  logic          push_pc1,
  input  logic          push_pc2,
  input  logic          push_ccr,
  input  logic          seq_pop_pc1,
  input  logic          seq_pop_pc2,
  input  logic          seq_pop_ccr,
  input  logic          seq_mem_r,
  input  logic          seq_mem_w,
  input  logic          seq_stack,
  input  logic          seq_freeze_pc,
  input  logic          seq_freeze_cu,
  input  pc_sel_t       seq_pc_sel,
  input  logic          branch_taken,
  input  logic          load_use,
  output logic          mem_r,
  output logic          mem_w,
  output logic          stack,
  output logic          freeze_cu,
  output logic          fetch_pc_enable,
  output logic          pop_pc1,
  output logic          pop_pc2,
  output logic          pop_ccr,
  output logic          call,
  output logic          ret,
  output logic          rti,
  output mem_data_sel_t mem_data_sel,
  output pc_sel_t       pc_sel
);

  // plain instructions and stack sequences share the memory port
  assign mem_r = mem_r_dec | seq_mem_r;
  assign mem_w = mem_w_dec | seq_mem_w;
  assign stack = stack_dec | seq_stack;

  // a load-use stall freezes decode in the same cycle
  assign freeze_cu       = load_use | seq_freeze_cu;
  assign fetch_pc_enable = ~seq_freeze_pc;

  // pops steer the memory read data into pc or ccr
  assign pop_pc1 = seq_pop_pc1;
  assign pop_pc2 = seq_pop_pc2;
  assign pop_ccr = seq_pop_ccr;

  // the datapath backs pc up by one on these
  assign call = call_dec;
  assign ret  = ret_dec;
  assign rti  = rti_dec;

  always_comb
  begin
    if (push_pc1)
      mem_data_sel = md_sel_pc_hi;
    else if (push_pc2)
      mem_data_sel = md_sel_pc_lo;
    else if (push_ccr)
      mem_data_sel = md_sel_ccr;
    else
      mem_data_sel = md_sel_reg;
  end

  // a sequence overrides a branch in the same cycle
  always_comb
  begin
    if (seq_pc_sel != pc_sel_seq)
      pc_sel = seq_pc_sel;
    else if (branch_taken)
      pc_sel = pc_sel_branch;
    else
      pc_sel = pc_sel_seq;
  end

  a_push_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0({push_pc1, push_pc2, push_ccr}));

  // fetch must be stalled while the sequencer owns the stack
  a_stack_frozen: assert property (@(posedge clk) disable iff (rst)
    seq_stack |-> !fetch_pc_enable);

endmodule

`default_nettype wire

//--- stack_sequencer.sv
`default_nettype none

module stack_sequencer
  import cu_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    call_dec,
  input  logic    ret_dec,
  input  logic    rti_dec,
  input  logic    ldm_dec,
  input  logic    load_use,
  input  logic    int_req,
  output logic    int_ack,
  output logic    push_pc1,
  output logic    push_pc2,
  output logic    push_ccr,
  output logic    pop_pc1,
  output logic    pop_pc2,
  output logic    pop_ccr,
  output logic    seq_mem_r,
  output logic    seq_mem_w,
  output logic    seq_stack,
  output logic    seq_freeze_pc,
  output logic    seq_freeze_cu,
  output pc_sel_t seq_pc_sel
);

  seq_state_t state;
  seq_state_t state_nxt;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state   <= st_idle;
      int_ack <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      // ack goes up together with st_int_wait and down when release ends
      if (state == st_idle && int_req)
        int_ack <= 1'b1;
      else if (state == st_int_release && !int_req)
        int_ack <= 1'b0;
    end
  end

  // only idle looks at triggers, so a running sequence is never cut short
  always_comb
  begin
    state_nxt = state;
    case (state)
      st_idle:
      begin
        if (int_req)
          state_nxt = st_int_wait;
        else if (call_dec)
          state_nxt = st_call_push1;
        else if (rti_dec)
          state_nxt = st_rti_pop_ccr;
        else if (ret_dec)
          state_nxt = st_ret_pop2;
        else if (ldm_dec)
          state_nxt = st_ldm_hold;
      end
      st_ldm_hold:      state_nxt = st_idle;
      st_call_push1:    state_nxt = st_call_push2;
      st_call_push2:    state_nxt = st_call_load;
      st_call_load:     state_nxt = st_idle;
      st_ret_pop2:      state_nxt = st_ret_pop1;
      st_ret_pop1:      state_nxt = st_idle;
      st_rti_pop_ccr:   state_nxt = st_rti_pop2;
      st_rti_pop2:      state_nxt = st_rti_pop1;
      st_rti_pop1:      state_nxt = st_idle;
      st_int_wait:
      begin
        // let an ldm or a load-use stall drain before freezing
        if (ldm_dec || load_use)
          state_nxt = st_int_hazard;
        else
          state_nxt = st_int_freeze_pc;
      end
      st_int_hazard:    state_nxt = st_int_freeze_pc;
      st_int_freeze_pc: state_nxt = st_int_freeze_cu;
      st_int_freeze_cu: state_nxt = st_int_push1;
      st_int_push1:     state_nxt = st_int_push2;
      st_int_push2:     state_nxt = st_int_push_ccr;
      st_int_push_ccr:  state_nxt = st_int_release;
      st_int_release:
      begin
        if (!int_req)
          state_nxt = st_idle;
      end
      default:          state_nxt = st_idle;
    endcase
  end

  // moore outputs
  always_comb
  begin
    push_pc1      = 1'b0;
    push_pc2      = 1'b0;
    push_ccr      = 1'b0;
    pop_pc1       = 1'b0;
    pop_pc2       = 1'b0;
    pop_ccr       = 1'b0;
    seq_mem_r     = 1'b0;
    seq_mem_w     = 1'b0;
    seq_stack     = 1'b0;
    seq_freeze_pc = 1'b0;
    seq_freeze_cu = 1'b0;
    seq_pc_sel    = pc_sel_seq;

    case (state)
      st_ldm_hold:
      begin
        seq_freeze_cu = 1'b1;
      end
      st_call_push1, st_int_push1:
      begin
        push_pc1      = 1'b1;
        seq_mem_w     = 1'b1;
        seq_stack     = 1'b1;
        seq_freeze_pc = 1'b1;
        seq_freeze_cu = 1'b1;
      end
      st_call_push2, st_int_push2:
      begin
        push_pc2      = 1'b1;
        seq_mem_w     = 1'b1;
        seq_stack     = 1'b1;
        seq_freeze_pc = 1'b1;
        seq_freeze_cu = 1'b1;
      end
      st_call_load:
      begin
        seq_pc_sel = pc_sel_call;
      end
      st_ret_pop2, st_rti_pop2:
      begin
        pop_pc2       = 1'b1;
        seq_mem_r     = 1'b1;
        seq_stack     = 1'b1;
        seq_freeze_pc = 1'b1;
        seq_freeze_cu = 1'b1;
      end
      st_ret_pop1, st_rti_pop1:
      begin
        pop_pc1       = 1'b1;
        seq_mem_r     = 1'b1;
        seq_stack     = 1'b1;
        seq_freeze_pc = 1'b1;
        seq_freeze_cu = 1'b1;
      end
      st_rti_pop_ccr:
      begin
        pop_ccr       = 1'b1;
        seq_mem_r     = 1'b1;
        seq_stack     = 1'b1;
        seq_freeze_pc = 1'b1;
        seq_freeze_cu = 1'b1;
      end
      st_int_freeze_pc:
      begin
        seq_freeze_pc = 1'b1;
      end
      st_int_freeze_cu:
      begin
        seq_freeze_pc = 1'b1;
        seq_freeze_cu = 1'b1;
      end
      st_int_push_ccr:
      begin
        push_ccr      = 1'b1;
        seq_mem_w     = 1'b1;
        seq_stack     = 1'b1;
        seq_freeze_pc = 1'b1;
        seq_freeze_cu = 1'b1;
        seq_pc_sel    = pc_sel_int_vec;
      end
      default:
      begin
        // idle, wait, hazard and release drive nothing
      end
    endcase
  end

  // the requester may only drop int_req after it has seen int_ack
  a_ack_held: assert property (@(posedge clk) disable iff (rst)
    int_ack && int_req |=> int_ack);

  a_rw_excl: assert property (@(posedge clk) disable iff (rst)
    !(seq_mem_r && seq_mem_w));

endmodule

`default_nettype wire

//--- instr_decoder.sv
`default_nettype none

module instr_decoder
  import cu_pkg::*;
(
  input  opcode_t  opcode,
  output logic     reg_wr,
  output logic     ldm_dec,
  output logic     mem_r_dec,
  output logic     mem_w_dec,
  output logic     mem_to_reg,
  output logic     stack_dec,
  output logic     port_r,
  output logic     port_w,
  output logic     branch,
  output logic     call_dec,
  output logic     ret_dec,
  output logic     rti_dec,
  output alu_op_t  alu_op,
  output alu_src_t alu_src
);

  // the alu decodes its own operation from the opcode bits
  assign alu_op = opcode;

  always_comb
  begin
    reg_wr     = 1'b0;
    ldm_dec    = 1'b0;
    mem_r_dec  = 1'b0;
    mem_w_dec  = 1'b0;
    mem_to_reg = 1'b0;
    stack_dec  = 1'b0;
    port_r     = 1'b0;
    port_w     = 1'b0;
    branch     = 1'b0;
    call_dec   = 1'b0;
    ret_dec    = 1'b0;
    rti_dec    = 1'b0;
    alu_src    = alu_src_reg;

    case (opcode) inside
      op_nop:
      begin
        // bubble, all controls stay low
      end
      [op_alu_lo:op_alu_hi]:
      begin
        reg_wr = 1'b1;
      end
      op_out:
      begin
        port_w = 1'b1;
      end
      op_push:
      begin
        mem_w_dec = 1'b1;
        stack_dec = 1'b1;
      end
      op_ldd:
      begin
        reg_wr     = 1'b1;
        mem_r_dec  = 1'b1;
        mem_to_reg = 1'b1;
        alu_src    = alu_src_ofs;
      end
      op_ldm:
      begin
        reg_wr  = 1'b1;
        ldm_dec = 1'b1;
        alu_src = alu_src_imm;
      end
      op_pop:
      begin
        reg_wr     = 1'b1;
        mem_r_dec  = 1'b1;
        mem_to_reg = 1'b1;
        stack_dec  = 1'b1;
      end
      op_std:
      begin
        mem_w_dec = 1'b1;
        alu_src   = alu_src_ofs;
      end
      [op_jmp_lo:op_jmp_hi]:
      begin
        // taken or not is resolved later, see branch_taken
        branch = 1'b1;
      end
      op_call:
      begin
        call_dec = 1'b1;
      end
      op_ret:
      begin
        ret_dec = 1'b1;
      end
      op_rti:
      begin
        rti_dec = 1'b1;
      end
      op_in:
      begin
        reg_wr = 1'b1;
        port_r = 1'b1;
      end
      default:
      begin
        // unused opcodes behave as nop
      end
    endcase
  end

endmodule

`default_nettype wire

//--- cu_pkg.sv
`default_nettype none

package cu_pkg;

  // opcode as held in the decode stage
  typedef logic [4:0] opcode_t;
  // the execute stage receives the opcode unchanged as its operation code
  typedef logic [4:0] alu_op_t;
  typedef logic [1:0] alu_src_t;
  typedef logic [1:0] pc_sel_t;
  typedef logic [1:0] mem_data_sel_t;

  // single word opcodes
  localparam opcode_t op_nop  = 5'b00000;
  localparam opcode_t op_out  = 5'b00110;
  localparam opcode_t op_push = 5'b00111;
  localparam opcode_t op_ldd  = 5'b10000;
  localparam opcode_t op_ldm  = 5'b10001;
  localparam opcode_t op_pop  = 5'b10010;
  localparam opcode_t op_std  = 5'b10011;
  localparam opcode_t op_call = 5'b11000;
  localparam opcode_t op_ret  = 5'b11001;
  localparam opcode_t op_rti  = 5'b11010;
  localparam opcode_t op_in   = 5'b11011;

  // opcode ranges shared by a whole group
  localparam opcode_t op_alu_lo = 5'b01000;
  localparam opcode_t op_alu_hi = 5'b01111;
  localparam opcode_t op_jmp_lo = 5'b10100;
  localparam opcode_t op_jmp_hi = 5'b10111;

  // bit 1 picks the immediate and bit 0 the port or offset operand
  localparam alu_src_t alu_src_reg = 2'b00;
  localparam alu_src_t alu_src_ofs = 2'b01;
  localparam alu_src_t alu_src_imm = 2'b10;

  // next pc source
  localparam pc_sel_t pc_sel_seq     = 2'b00;
  localparam pc_sel_t pc_sel_branch  = 2'b01;
  localparam pc_sel_t pc_sel_int_vec = 2'b10;
  localparam pc_sel_t pc_sel_call    = 2'b11;

  // data written to memory on a store or push
  localparam mem_data_sel_t md_sel_reg   = 2'b00;
  localparam mem_data_sel_t md_sel_pc_hi = 2'b01;
  localparam mem_data_sel_t md_sel_pc_lo = 2'b10;
  localparam mem_data_sel_t md_sel_ccr   = 2'b11;

  // eighteen states need a five bit code
  typedef enum logic [4:0] {
    st_idle,
    st_ldm_hold,
    st_call_push1, st_call_push2, st_call_load,
    st_ret_pop2, st_ret_pop1,
    st_rti_pop_ccr, st_rti_pop2, st_rti_pop1,
    st_int_wait, st_int_hazard,
    st_int_freeze_pc, st_int_freeze_cu,
    st_int_push1, st_int_push2, st_int_push_ccr,
    st_int_release
  } seq_state_t;

endpackage

`default_nettype wire
